/* term_pkg.sv */
package term_pkg;

    // Text grid and glyph cell geometry
    localparam int COLS        = 40;
    localparam int ROWS        = 15;
    localparam int CELL_W      = 8;
    localparam int CELL_H      = 16;
    localparam int CURSOR_LINE = 13; // Underline row inside a cell

    typedef logic [5:0]   col_t;
    typedef logic [3:0]   row_t;
    typedef logic [8:0]   px_x_t;
    typedef logic [7:0]   px_y_t;
    typedef logic [2:0]   colour_t;  // R, G, B
    typedef logic [6:0]   ascii_t;
    typedef logic [127:0] glyph_t;   // Bit 127 is the top-left pixel

    localparam colour_t FG_COLOUR = 3'b010;
    localparam colour_t BG_COLOUR = 3'b000;

    localparam ascii_t CH_NUL   = 7'h00;
    localparam ascii_t CH_BS    = 7'h08;
    localparam ascii_t CH_LF    = 7'h0A;
    localparam ascii_t CH_CR    = 7'h0D;  // Home
    localparam ascii_t CH_UP    = 7'h11;  // DC1
    localparam ascii_t CH_LEFT  = 7'h12;  // DC2
    localparam ascii_t CH_DOWN  = 7'h13;  // DC3
    localparam ascii_t CH_RIGHT = 7'h14;  // DC4
    localparam ascii_t CH_END   = 7'h17;  // ETB
    localparam ascii_t CH_DEL   = 7'h7F;
    localparam ascii_t CH_SPACE = 7'h20;
    localparam ascii_t PRINT_LO = 7'h20;
    localparam ascii_t PRINT_HI = 7'h7E;

    typedef enum logic [2:0] {
        ED_IDLE,  // Waiting for a key
        ED_HIDE,  // Waiting for the underline to go away
        ED_MOVE,
        ED_DRAW,
        ED_WAIT   // Waiting for the plotter
    } editor_state_e;

endpackage

/* pixel_bus_if.sv */
`timescale 1ns/1ps

interface pixel_bus_if;

    logic              req;
    term_pkg::px_x_t   x;
    term_pkg::px_y_t   y;
    term_pkg::colour_t colour;
    logic              grant;  // One-cycle pulse, pixel taken

    modport requester (
        output req,
        output x,
        output y,
        output colour,
        input  grant
    );

    modport arbiter (
        input  req,
        input  x,
        input  y,
        input  colour,
        output grant
    );

endinterface

/* glyph_rom.sv */
`timescale 1ns/1ps

module glyph_rom (
    input  term_pkg::ascii_t char_code,
    output term_pkg::glyph_t bitmap
);

    // One byte per cell row, MSB leftmost, rows 2 to 11 carry the shape
    always_comb
    begin
        case (char_code)
            7'h30: bitmap = 128'h0000_386C_C6C6_D6D6_C6C6_6C38_0000_0000; // 0
            7'h31: bitmap = 128'h0000_1838_7818_1818_1818_187E_0000_0000;
            7'h32: bitmap = 128'h0000_7CC6_060C_1830_60C0_C6FE_0000_0000;
            7'h33: bitmap = 128'h0000_7CC6_0606_3C06_0606_C67C_0000_0000;
            7'h34: bitmap = 128'h0000_0C1C_3C6C_CCFE_0C0C_0C1E_0000_0000;
            7'h35: bitmap = 128'h0000_FEC0_C0C0_FC06_0606_C67C_0000_0000;
            7'h36: bitmap = 128'h0000_3860_C0C0_FCC6_C6C6_C67C_0000_0000;
            7'h37: bitmap = 128'h0000_FEC6_0606_0C18_3030_3030_0000_0000;
            7'h38: bitmap = 128'h0000_7CC6_C6C6_7CC6_C6C6_C67C_0000_0000;
            7'h39: bitmap = 128'h0000_7CC6_C6C6_7E06_0606_0C78_0000_0000; // 9
            7'h41: bitmap = 128'h0000_1038_6CC6_C6FE_C6C6_C6C6_0000_0000; // A
            7'h42: bitmap = 128'h0000_FC66_6666_7C66_6666_66FC_0000_0000;
            7'h43: bitmap = 128'h0000_3C66_C2C0_C0C0_C0C2_663C_0000_0000;
            7'h44: bitmap = 128'h0000_F86C_6666_6666_6666_6CF8_0000_0000;
            7'h45: bitmap = 128'h0000_FE66_6268_7868_6062_66FE_0000_0000;
            7'h46: bitmap = 128'h0000_FE66_6268_7868_6060_60F0_0000_0000;
            7'h47: bitmap = 128'h0000_3C66_C2C0_C0DE_C6C6_663A_0000_0000;
            7'h48: bitmap = 128'h0000_C6C6_C6C6_FEC6_C6C6_C6C6_0000_0000;
            7'h49: bitmap = 128'h0000_3C18_1818_1818_1818_183C_0000_0000;
            7'h4A: bitmap = 128'h0000_1E0C_0C0C_0C0C_CCCC_CC78_0000_0000;
            7'h4B: bitmap = 128'h0000_E666_666C_7878_6C66_66E6_0000_0000;
            7'h4C: bitmap = 128'h0000_F060_6060_6060_6062_66FE_0000_0000;
            7'h4D: bitmap = 128'h0000_C6EE_FEFE_D6C6_C6C6_C6C6_0000_0000;
            7'h4E: bitmap = 128'h0000_C6E6_F6FE_DECE_C6C6_C6C6_0000_0000;
            7'h4F: bitmap = 128'h0000_7CC6_C6C6_C6C6_C6C6_C67C_0000_0000;
            7'h50: bitmap = 128'h0000_FC66_6666_7C60_6060_60F0_0000_0000;
            7'h51: bitmap = 128'h0000_7CC6_C6C6_C6C6_C6D6_DE7C_0000_0000;
            7'h52: bitmap = 128'h0000_FC66_6666_7C6C_6666_66E6_0000_0000;
            7'h53: bitmap = 128'h0000_7CC6_C660_380C_06C6_C67C_0000_0000;
            7'h54: bitmap = 128'h0000_7E7E_5A18_1818_1818_183C_0000_0000;
            7'h55: bitmap = 128'h0000_C6C6_C6C6_C6C6_C6C6_C67C_0000_0000;
            7'h56: bitmap = 128'h0000_C6C6_C6C6_C6C6_C66C_3810_0000_0000;
            7'h57: bitmap = 128'h0000_C6C6_C6C6_D6D6_D6FE_EE6C_0000_0000;
            7'h58: bitmap = 128'h0000_C6C6_6C7C_3838_7C6C_C6C6_0000_0000;
            7'h59: bitmap = 128'h0000_6666_6666_3C18_1818_183C_0000_0000;
            7'h5A: bitmap = 128'h0000_FEC6_860C_1830_60C2_C6FE_0000_0000; // Z
            default: bitmap = '0; // Space and codes without a shape
        endcase
    end

endmodule

/* editor_ctrl.sv */
`timescale 1ns/1ps

module editor_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             key_valid,
    input  term_pkg::ascii_t key_code,
    output logic             busy,
    output logic             draw,
    output term_pkg::col_t   draw_col,
    output term_pkg::row_t   draw_row,
    output term_pkg::ascii_t draw_char,
    input  logic             draw_done,
    output term_pkg::col_t   cursor_col,
    output term_pkg::row_t   cursor_row,
    output logic             hide,
    input  logic             hidden
);

    localparam term_pkg::col_t LAST_COL = term_pkg::col_t'(term_pkg::COLS - 1);
    localparam term_pkg::row_t LAST_ROW = term_pkg::row_t'(term_pkg::ROWS - 1);

    term_pkg::editor_state_e state;
    term_pkg::ascii_t        key_q;
    term_pkg::col_t          col_q;
    term_pkg::col_t          next_col;
    term_pkg::row_t          row_q;
    term_pkg::row_t          next_row;
    logic                    key_print;
    logic                    key_ctrl;
    logic                    q_print;

    assign key_print = (key_code >= term_pkg::PRINT_LO) && (key_code <= term_pkg::PRINT_HI);
    assign key_ctrl  = key_code inside {term_pkg::CH_BS, term_pkg::CH_LF, term_pkg::CH_CR,
                                        term_pkg::CH_UP, term_pkg::CH_LEFT, term_pkg::CH_DOWN,
                                        term_pkg::CH_RIGHT, term_pkg::CH_END, term_pkg::CH_DEL};
    assign q_print   = (key_q >= term_pkg::PRINT_LO) && (key_q <= term_pkg::PRINT_HI);

    // Position after the latched command, clamped to the grid
    always_comb
    begin
        next_col = col_q;
        next_row = row_q;
        case (key_q)
            term_pkg::CH_CR:  next_col = '0;
            term_pkg::CH_END: next_col = LAST_COL;
            term_pkg::CH_LF:
                if (row_q != LAST_ROW)
                begin
                    next_col = '0;
                    next_row = row_q + 1'b1;
                end
            term_pkg::CH_UP:
                if (row_q != '0)
                    next_row = row_q - 1'b1;
            term_pkg::CH_DOWN:
                if (row_q != LAST_ROW)
                    next_row = row_q + 1'b1;
            term_pkg::CH_LEFT, term_pkg::CH_BS:
                if (col_q != '0)
                    next_col = col_q - 1'b1;
                else if (row_q != '0)
                begin
                    next_col = LAST_COL;  // End of previous row
                    next_row = row_q - 1'b1;
                end
            term_pkg::CH_DEL: ;           // Erase in place
            default:                      // Right arrow and printable advance
                if (col_q != LAST_COL)
                    next_col = col_q + 1'b1;
                else if (row_q != LAST_ROW)
                begin
                    next_col = '0;
                    next_row = row_q + 1'b1;
                end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= term_pkg::ED_IDLE;
            key_q <= term_pkg::CH_NUL;
            col_q <= '0;
            row_q <= '0;
        end
        else
        begin
            case (state)
                term_pkg::ED_IDLE:
                    if (key_valid && (key_print || key_ctrl))
                    begin
                        key_q <= key_code;
                        state <= term_pkg::ED_HIDE;
                    end
                term_pkg::ED_HIDE:
                    if (hidden)
                        state <= (q_print || key_q == term_pkg::CH_DEL) ?
                                 term_pkg::ED_DRAW : term_pkg::ED_MOVE;
                term_pkg::ED_MOVE:
                begin
                    col_q <= next_col;
                    row_q <= next_row;
                    // Backspace erases the cell it just moved onto
                    state <= (key_q == term_pkg::CH_BS) ? term_pkg::ED_DRAW : term_pkg::ED_IDLE;
                end
                term_pkg::ED_DRAW:
                    state <= term_pkg::ED_WAIT;
                term_pkg::ED_WAIT:
                    if (draw_done)
                        state <= q_print ? term_pkg::ED_MOVE : term_pkg::ED_IDLE;
                default:
                    state <= term_pkg::ED_IDLE;
            endcase
        end
    end

    assign busy       = (state != term_pkg::ED_IDLE);
    assign hide       = (state != term_pkg::ED_IDLE);
    assign draw       = (state == term_pkg::ED_DRAW);
    assign draw_char  = q_print ? key_q : term_pkg::CH_SPACE;  // BS and DEL draw a blank
    assign draw_col   = col_q;
    assign draw_row   = row_q;
    assign cursor_col = col_q;
    assign cursor_row = row_q;

endmodule

/* glyph_plotter.sv */
`timescale 1ns/1ps

module glyph_plotter (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             draw,
    input  term_pkg::col_t   draw_col,
    input  term_pkg::row_t   draw_row,
    input  term_pkg::ascii_t draw_char,
    output logic             draw_done,
    pixel_bus_if.requester   bus
);

    term_pkg::glyph_t rom_bitmap;
    term_pkg::glyph_t shift_q;   // Current pixel in bit 127
    term_pkg::col_t   col_q;
    term_pkg::row_t   row_q;
    logic [6:0]       pix_cnt;
    logic             active;

    glyph_rom rom0 (
        .char_code (draw_char),
        .bitmap    (rom_bitmap)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            active    <= 1'b0;
            pix_cnt   <= '0;
            draw_done <= 1'b0;
        end
        else
        begin
            draw_done <= 1'b0;
            if (draw)
            begin
                active  <= 1'b1;
                pix_cnt <= '0;
            end
            else if (active && bus.grant)
            begin
                pix_cnt <= pix_cnt + 1'b1;
                if (pix_cnt == 7'd127)
                begin
                    active    <= 1'b0;
                    draw_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (draw)
        begin
            shift_q <= rom_bitmap;
            col_q   <= draw_col;
            row_q   <= draw_row;
        end
        else if (active && bus.grant)
            shift_q <= {shift_q[126:0], 1'b0};
    end

    // Cell origin plus column and row inside the cell
    assign bus.req    = active;
    assign bus.x      = {col_q, pix_cnt[2:0]};
    assign bus.y      = {row_q, pix_cnt[6:3]};
    assign bus.colour = shift_q[127] ? term_pkg::FG_COLOUR : term_pkg::BG_COLOUR;

endmodule

/* cursor_blinker.sv */
`timescale 1ns/1ps

module cursor_blinker #(
    parameter int BLINK_CYCLES = 25_000_000
) (
    input  logic           clk,
    input  logic           rst_n,
    input  term_pkg::col_t cursor_col,
    input  term_pkg::row_t cursor_row,
    input  logic           hide,
    output logic           hidden,
    pixel_bus_if.requester bus
);

    localparam int CNT_W = $clog2(BLINK_CYCLES);
    localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(BLINK_CYCLES - 1);

    logic [CNT_W-1:0] blink_cnt;
    logic             shown;     // Underline currently on screen
    logic             painting;
    logic [2:0]       pix_cnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            blink_cnt <= '0;
            shown     <= 1'b0;
            painting  <= 1'b0;
            pix_cnt   <= '0;
        end
        else if (painting)
        begin
            if (bus.grant)
            begin
                pix_cnt <= pix_cnt + 1'b1;  // Wraps back to 0 after pixel 7
                if (pix_cnt == 3'd7)
                    painting <= 1'b0;
            end
        end
        else if (hide)
        begin
            blink_cnt <= '0;
            if (shown)
            begin
                painting <= 1'b1;  // Single erase pass
                shown    <= 1'b0;
            end
        end
        else if (blink_cnt == LAST_TICK)
        begin
            blink_cnt <= '0;
            painting  <= 1'b1;
            shown     <= ~shown;
        end
        else
            blink_cnt <= blink_cnt + 1'b1;
    end

    assign hidden = hide && !painting && !shown;

    assign bus.req    = painting;
    assign bus.x      = term_pkg::px_x_t'(cursor_col) * term_pkg::px_x_t'(term_pkg::CELL_W)
                      + term_pkg::px_x_t'(pix_cnt);
    assign bus.y      = term_pkg::px_y_t'(cursor_row) * term_pkg::px_y_t'(term_pkg::CELL_H)
                      + term_pkg::px_y_t'(term_pkg::CURSOR_LINE);
    assign bus.colour = shown ? term_pkg::FG_COLOUR : term_pkg::BG_COLOUR;

endmodule

/* plot_arbiter.sv */
`timescale 1ns/1ps

module plot_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    pixel_bus_if.arbiter      glyph_bus,
    pixel_bus_if.arbiter      cursor_bus,
    output logic              plot,
    output term_pkg::px_x_t   x,
    output term_pkg::px_y_t   y,
    output term_pkg::colour_t colour
);

    // Glyph writes always win
    assign glyph_bus.grant  = glyph_bus.req;
    assign cursor_bus.grant = cursor_bus.req && !glyph_bus.req;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            plot <= 1'b0;
        else
            plot <= glyph_bus.grant || cursor_bus.grant;
    end

    always_ff @(posedge clk)
    begin
        if (glyph_bus.grant)
        begin
            x      <= glyph_bus.x;
            y      <= glyph_bus.y;
            colour <= glyph_bus.colour;
        end
        else if (cursor_bus.grant)
        begin
            x      <= cursor_bus.x;
            y      <= cursor_bus.y;
            colour <= cursor_bus.colour;
        end
    end

endmodule

/* text_terminal.sv */
`timescale 1ns/1ps

module text_terminal #(
    parameter int BLINK_CYCLES = 25_000_000  // Half a second at 50 MHz
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              key_valid,
    input  term_pkg::ascii_t  key_code,
    output logic              plot,
    output term_pkg::px_x_t   x,
    output term_pkg::px_y_t   y,
    output term_pkg::colour_t colour,
    output logic              busy
);

    logic             draw;
    logic             draw_done;
    term_pkg::col_t   draw_col;
    term_pkg::row_t   draw_row;
    term_pkg::ascii_t draw_char;
    term_pkg::col_t   cursor_col;
    term_pkg::row_t   cursor_row;
    logic             hide;
    logic             hidden;

    pixel_bus_if glyph_bus ();
    pixel_bus_if cursor_bus ();

    editor_ctrl editor0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .busy       (busy),
        .draw       (draw),
        .draw_col   (draw_col),
        .draw_row   (draw_row),
        .draw_char  (draw_char),
        .draw_done  (draw_done),
        .cursor_col (cursor_col),
        .cursor_row (cursor_row),
        .hide       (hide),
        .hidden     (hidden)
    );

    glyph_plotter plotter0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .draw      (draw),
        .draw_col  (draw_col),
        .draw_row  (draw_row),
        .draw_char (draw_char),
        .draw_done (draw_done),
        .bus       (glyph_bus.requester)
    );

    cursor_blinker #(
        .BLINK_CYCLES (BLINK_CYCLES)
    ) blinker0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cursor_col (cursor_col),
        .cursor_row (cursor_row),
        .hide       (hide),
        .hidden     (hidden),
        .bus        (cursor_bus.requester)
    );

    plot_arbiter arbiter0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .glyph_bus  (glyph_bus.arbiter),
        .cursor_bus (cursor_bus.arbiter),
        .plot       (plot),
        .x          (x),
        .y          (y),
        .colour     (colour)
    );

endmodule

/* tb_text_terminal.sv */
`timescale 1ns/1ps

module tb_text_terminal;

    localparam int BLINK_CYCLES = 64;
    localparam int KEY_CYCLES   = 160;  // Worst key: leftover blink, erase pass, 128 glyph writes
    localparam int NUM_KEYS     = 90;
    localparam int WATCHDOG_NS  = 2 * 10 * (NUM_KEYS * KEY_CYCLES + 3 * BLINK_CYCLES + 20);

    localparam term_pkg::ascii_t CH_A        = 7'h41;
    localparam term_pkg::glyph_t GLYPH_A     = 128'h0000_1038_6CC6_C6FE_C6C6_C6C6_0000_0000;
    localparam term_pkg::glyph_t GLYPH_SPACE = '0;

    typedef struct packed {
        term_pkg::px_x_t   x;
        term_pkg::px_y_t   y;
        term_pkg::colour_t colour;
    } wr_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              key_valid;
    term_pkg::ascii_t  key_code;
    logic              plot;
    term_pkg::px_x_t   x;
    term_pkg::px_y_t   y;
    term_pkg::colour_t colour;
    logic              busy;

    logic             capture = 1'b0;
    wr_t              cap_q[$];
    int               errors = 0;
    int               tests_failed = 0;
    int               test_count = 0;
    integer           seed = 32'hbd5334b1;
    int               m_col;       // Reference cursor position
    int               m_row;
    term_pkg::ascii_t moves[$];

    text_terminal #(
        .BLINK_CYCLES (BLINK_CYCLES)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key_code  (key_code),
        .plot      (plot),
        .x         (x),
        .y         (y),
        .colour    (colour),
        .busy      (busy)
    );

    always #5 clk = ~clk;

    // Output register is stable mid-cycle
    always @(negedge clk)
    begin
        if (capture && plot)
            cap_q.push_back({x, y, colour});
    end

    always @(negedge clk)
    begin
        if (rst_n && plot)
            assert (x < 320 && y < 240)
            else
            begin
                $display("** Error: plot outside the frame, x = %h, y = %h", x, y);
                errors++;
            end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    task automatic check_val(input string name, input int got, input int exp);
        assert (got == exp)
        else
        begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int first);
        test_count++;
        if (errors == first)
            $display("Test %0d %s: passed", test_count, name);
        else
        begin
            tests_failed++;
            $display("Test %0d %s: FAILED with %0d errors", test_count, name, errors - first);
        end
    endtask

    // Cursor rules of the terminal, clamped to the grid
    task automatic step_model(input term_pkg::ascii_t code);
        case (code)
            term_pkg::CH_CR:  m_col = 0;
            term_pkg::CH_END: m_col = term_pkg::COLS - 1;
            term_pkg::CH_LF:
                if (m_row < term_pkg::ROWS - 1)
                begin
                    m_col = 0;
                    m_row++;
                end
            term_pkg::CH_UP:
                if (m_row > 0)
                    m_row--;
            term_pkg::CH_DOWN:
                if (m_row < term_pkg::ROWS - 1)
                    m_row++;
            term_pkg::CH_LEFT, term_pkg::CH_BS:
                if (m_col > 0)
                    m_col--;
                else if (m_row > 0)
                begin
                    m_col = term_pkg::COLS - 1;
                    m_row--;
                end
            term_pkg::CH_DEL: ;
            default:  // Printable and right arrow
                if (m_col < term_pkg::COLS - 1)
                    m_col++;
                else if (m_row < term_pkg::ROWS - 1)
                begin
                    m_col = 0;
                    m_row++;
                end
        endcase
    endtask

    // Called 1 ns after a rising edge with busy low
    task automatic run_key(input term_pkg::ascii_t code, input bit check_colour,
                           input term_pkg::glyph_t bits, input bit poke);
        int old_col;
        int old_row;
        int d_col;
        int d_row;
        int base;
        int i;
        bit drawn;
        drawn = (code >= term_pkg::PRINT_LO && code <= term_pkg::PRINT_HI)
                || code == term_pkg::CH_BS || code == term_pkg::CH_DEL;
        old_col = m_col;
        old_row = m_row;
        if (code == term_pkg::CH_BS)
            step_model(code);  // Erase lands on the new cell
        d_col = m_col;
        d_row = m_row;
        if (code != term_pkg::CH_BS)
            step_model(code);
        cap_q.delete();
        capture   = 1'b1;
        key_valid = 1'b1;
        key_code  = code;
        @(posedge clk);
        #1;
        key_valid = 1'b0;
        check_val("busy", busy, 1);
        if (poke)
        begin
            key_valid = 1'b1;
            key_code  = 7'h42;  // Must be dropped
            @(posedge clk);
            #1;
            key_valid = 1'b0;
        end
        while (busy)
        begin
            @(posedge clk);
            #1;
        end
        capture = 1'b0;
        base = cap_q.size() - (drawn ? 128 : 0);
        assert (base >= 0 && base <= 16)
        else
        begin
            $display("** Error: plot count = %h, expected %h plus at most 16 underline writes",
                     cap_q.size(), drawn ? 128 : 0);
            errors++;
        end
        if (base >= 0 && base <= 16)
        begin
            // Only underline traffic at the old cursor may precede the glyph
            for (i = 0; i < base; i++)
            begin
                check_val("underline y", cap_q[i].y, old_row * 16 + term_pkg::CURSOR_LINE);
                check_val("underline x div 8", cap_q[i].x / 8, old_col);
            end
            if (base > 0)
                check_val("erase colour", cap_q[base-1].colour, term_pkg::BG_COLOUR);
            for (i = 0; drawn && i < 128; i++)
            begin
                check_val("x", cap_q[base+i].x, d_col * 8 + i % 8);
                check_val("y", cap_q[base+i].y, d_row * 16 + i / 8);
                if (check_colour)
                    check_val("colour", cap_q[base+i].colour,
                              bits[127-i] ? term_pkg::FG_COLOUR : term_pkg::BG_COLOUR);
            end
        end
        @(posedge clk);
        #1;
        check_val("busy", busy, 0);  // Nothing left pending
    endtask

    initial
    begin
        int first;
        int i;
        rst_n     = 1'b0;
        key_valid = 1'b0;
        key_code  = term_pkg::CH_NUL;
        m_col     = 0;
        m_row     = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        first = errors;
        check_val("plot", plot, 0);
        check_val("busy", busy, 0);
        cap_q.delete();
        capture = 1'b1;
        while (cap_q.size() < 16)
        begin
            @(posedge clk);
            #1;
        end
        capture = 1'b0;
        for (i = 0; i < 16; i++)
        begin
            check_val("x", cap_q[i].x, i % 8);
            check_val("y", cap_q[i].y, term_pkg::CURSOR_LINE);
            check_val("colour", cap_q[i].colour, i < 8 ? term_pkg::FG_COLOUR : term_pkg::BG_COLOUR);
        end
        report_test("reset and cursor blink", first);

        first = errors;
        run_key(CH_A, 1'b1, GLYPH_A, 1'b0);
        run_key(term_pkg::CH_SPACE, 1'b1, GLYPH_SPACE, 1'b0);
        report_test("glyph A and space", first);

        first = errors;
        run_key(term_pkg::CH_CR, 1'b0, GLYPH_SPACE, 1'b0);
        repeat (41)
            run_key(term_pkg::PRINT_LO + $unsigned($random(seed)) % 95, 1'b0, GLYPH_SPACE, 1'b0);
        report_test("row fill and wrap", first);

        first = errors;
        moves = '{term_pkg::CH_CR, term_pkg::CH_SPACE, term_pkg::CH_END, term_pkg::CH_SPACE,
                  term_pkg::CH_UP, term_pkg::CH_UP, term_pkg::CH_UP, term_pkg::CH_SPACE,
                  term_pkg::CH_CR, term_pkg::CH_DOWN, term_pkg::CH_LEFT, term_pkg::CH_SPACE,
                  term_pkg::CH_RIGHT, term_pkg::CH_SPACE, term_pkg::CH_LF, term_pkg::CH_SPACE};
        repeat (15)
            moves.push_back(term_pkg::CH_DOWN);  // Clamps at the bottom row
        moves.push_back(term_pkg::CH_SPACE);
        moves.push_back(term_pkg::CH_LF);
        moves.push_back(term_pkg::CH_SPACE);
        foreach (moves[k])
            run_key(moves[k], 1'b1, GLYPH_SPACE, 1'b0);
        report_test("cursor movement", first);

        first = errors;
        run_key(CH_A, 1'b1, GLYPH_A, 1'b0);
        run_key(term_pkg::CH_BS, 1'b1, GLYPH_SPACE, 1'b0);
        run_key(CH_A, 1'b1, GLYPH_A, 1'b0);
        run_key(term_pkg::CH_DEL, 1'b1, GLYPH_SPACE, 1'b0);
        run_key(CH_A, 1'b1, GLYPH_A, 1'b0);
        report_test("backspace and delete", first);

        first = errors;
        // Key lands while the underline is being painted
        while (!plot)
        begin
            @(posedge clk);
            #1;
        end
        run_key(CH_A, 1'b1, GLYPH_A, 1'b1);
        key_valid = 1'b1;
        key_code  = 7'h01;  // Not a known control
        @(posedge clk);
        #1;
        key_valid = 1'b0;
        check_val("busy", busy, 0);
        run_key(term_pkg::CH_SPACE, 1'b1, GLYPH_SPACE, 1'b0);
        report_test("keys while busy", first);

        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
                 test_count, tests_failed, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* verilog.f */
term_pkg.sv
pixel_bus_if.sv
glyph_rom.sv
editor_ctrl.sv
glyph_plotter.sv
cursor_blinker.sv
plot_arbiter.sv
text_terminal.sv
tb_text_terminal.sv
